//--- design/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    // Width constants.
    localparam int data_width     = 32;
    localparam int lane_count     = 4;
    localparam int reg_addr_width = 5;

    // Memory operations handled by the load/store unit.
    typedef enum logic [3:0] {
        op_ldb  = 4'd0,  // Load byte, sign extended.
        op_ldbu = 4'd1,  // Load byte, zero extended.
        op_ldh  = 4'd2,
        op_ldhu = 4'd3,
        op_ldw  = 4'd4,
        op_stb  = 4'd5,
        op_sth  = 4'd6,
        op_stw  = 4'd7,
        op_llw  = 4'd8,  // Load linked word.
        op_scw  = 4'd9   // Store conditional word.
    } mem_op_t;

    // Exception codes reported with a result.
    typedef enum logic [6:0] {
        exc_none = 7'h00,
        exc_ale  = 7'h09  // Address alignment error.
    } exc_code_t;

endpackage

`default_nettype wire

//--- design/data_bank.sv
`default_nettype none

// One byte lane of the data memory.
module data_bank #(
    parameter int addr_width = 6
) (
    input  logic                  clk,
    input  logic [addr_width-1:0] word_addr,
    input  logic                  lane_en,
    input  logic                  bank_write,
    input  logic [7:0]            wr_byte,
    output logic [7:0]            rd_byte
);

    localparam int depth = 1 << addr_width;

    logic [7:0] mem [depth];

    always_ff @(posedge clk) begin
        if (lane_en) begin
            if (bank_write) begin
                mem[word_addr] <= wr_byte;
            end
            else begin
                rd_byte <= mem[word_addr];  // Read data is valid next cycle.
            end
        end
    end

endmodule

`default_nettype wire

//--- design/mem_access.sv
`default_nettype none

module mem_access
    import lsu_pkg::*;
#(
    parameter int addr_width   = 6,
    parameter int result_depth = 4
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      in_valid,
    input  mem_op_t                   in_op,
    input  logic [addr_width+1:0]     in_addr,
    input  logic [data_width-1:0]     in_store_data,
    input  logic [reg_addr_width-1:0] in_reg_addr,
    input  logic                      credit_return,
    output logic                      in_ready,
    output logic [addr_width-1:0]     word_addr,
    output logic                      bank_write,
    output logic [lane_count-1:0]     lane_en,
    output logic [data_width-1:0]     wr_data,
    output logic                      stage_valid,
    output mem_op_t                   stage_op,
    output logic [1:0]                stage_offset,
    output logic [reg_addr_width-1:0] stage_reg_addr,
    output logic                      stage_exception,
    output exc_code_t                 stage_exc_code,
    output logic                      stage_sc_ok
);

    localparam int credit_width = $clog2(result_depth + 1);

    localparam logic [lane_count-1:0] byte_mask = 4'b0001;
    localparam logic [lane_count-1:0] half_mask = 4'b0011;
    localparam logic [lane_count-1:0] word_mask = 4'b1111;

    logic [credit_width-1:0] credits;
    logic                    accept;
    logic                    ll_bit;
    logic [1:0]              offset;
    logic [lane_count-1:0]   sel;
    logic [data_width-1:0]   store_word;
    logic                    is_store;
    logic                    misaligned;

    assign offset   = in_addr[1:0];
    assign in_ready = (credits != '0);
    assign accept   = in_valid && in_ready;

    // Lane selects, store data and alignment check.
    always_comb begin
        sel        = '0;
        store_word = '0;
        is_store   = 1'b0;
        misaligned = 1'b0;
        case (in_op)
            op_ldb, op_ldbu: begin
                sel = byte_mask << offset;
            end
            op_ldh, op_ldhu: begin
                sel        = half_mask << offset;
                misaligned = offset[0];
            end
            op_ldw, op_llw: begin
                sel        = word_mask;
                misaligned = (offset != 2'b00);
            end
            op_stb: begin
                sel        = byte_mask << offset;
                store_word = {lane_count{in_store_data[7:0]}};
                is_store   = 1'b1;
            end
            op_sth: begin
                sel        = half_mask << offset;
                store_word = {2{in_store_data[15:0]}};
                is_store   = 1'b1;
                misaligned = offset[0];
            end
            op_stw: begin
                sel        = word_mask;
                store_word = in_store_data;
                is_store   = 1'b1;
                misaligned = (offset != 2'b00);
            end
            op_scw: begin
                sel        = ll_bit ? word_mask : '0;  // Nothing written without a link.
                store_word = in_store_data;
                is_store   = 1'b1;
                misaligned = (offset != 2'b00);
            end
            default: begin
            end
        endcase
    end

    // Bank drive, sampled by the banks on the access edge.
    assign word_addr  = in_addr[addr_width+1:2];
    assign lane_en    = (accept && !misaligned) ? sel : '0;
    assign bank_write = accept && is_store && !misaligned;
    assign wr_data    = store_word;

    always_ff @(posedge clk) begin
        if (reset) begin
            credits <= credit_width'(result_depth);
        end
        else if (accept && !credit_return) begin
            credits <= credits - 1'b1;
        end
        else if (!accept && credit_return) begin
            credits <= credits + 1'b1;
        end
    end

    // Load-linked bit.
    always_ff @(posedge clk) begin
        if (reset) begin
            ll_bit <= 1'b0;
        end
        else if (accept && !misaligned) begin
            if (in_op == op_llw) begin
                ll_bit <= 1'b1;
            end
            else if (in_op == op_scw) begin
                ll_bit <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stage_valid <= 1'b0;
        end
        else begin
            stage_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            stage_op        <= in_op;
            stage_offset    <= offset;
            stage_reg_addr  <= in_reg_addr;
            stage_exception <= misaligned;
            stage_exc_code  <= misaligned ? exc_ale : exc_none;
            stage_sc_ok     <= (in_op == op_scw) && ll_bit;
        end
    end

endmodule

`default_nettype wire

//--- design/load_align.sv
`default_nettype none

module load_align
    import lsu_pkg::*;
#(
    parameter int result_depth = 4
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           stage_valid,
    input  mem_op_t                        stage_op,
    input  logic [1:0]                     stage_offset,
    input  logic [reg_addr_width-1:0]      stage_reg_addr,
    input  logic                           stage_exception,
    input  exc_code_t                      stage_exc_code,
    input  logic                           stage_sc_ok,
    input  logic [lane_count-1:0][7:0]     lane_data,
    input  logic                           out_pop,
    output logic                           out_valid,
    output logic                           out_reg_write_en,
    output logic [reg_addr_width-1:0]      out_reg_addr,
    output logic [data_width-1:0]          out_data,
    output logic                           out_exception,
    output exc_code_t                      out_exc_code,
    output logic                           credit_return
);

    localparam int ptr_width   = (result_depth > 1) ? $clog2(result_depth) : 1;
    localparam int count_width = $clog2(result_depth + 1);

    logic [data_width-1:0]     word;
    logic [7:0]                lane_byte;
    logic [15:0]               lane_half;
    logic [data_width-1:0]     res_data;
    logic                      res_write_en;

    logic [data_width-1:0]     q_data      [result_depth];
    logic                      q_write_en  [result_depth];
    logic [reg_addr_width-1:0] q_reg_addr  [result_depth];
    logic                      q_exception [result_depth];
    exc_code_t                 q_exc_code  [result_depth];

    logic [ptr_width-1:0]      wr_ptr;
    logic [ptr_width-1:0]      rd_ptr;
    logic [count_width-1:0]    count;
    logic                      pop;

    function automatic logic [ptr_width-1:0] next_ptr(input logic [ptr_width-1:0] ptr);
        if (ptr == ptr_width'(result_depth - 1)) begin
            return '0;
        end
        else begin
            return ptr + 1'b1;
        end
    endfunction

    // Lane 0 is the lowest byte.
    assign word      = lane_data;
    assign lane_byte = lane_data[stage_offset];
    assign lane_half = stage_offset[1] ? word[31:16] : word[15:0];

    always_comb begin
        res_data     = '0;
        res_write_en = 1'b0;
        if (!stage_exception) begin
            case (stage_op)
                op_ldb: begin
                    res_data     = {{24{lane_byte[7]}}, lane_byte};
                    res_write_en = 1'b1;
                end
                op_ldbu: begin
                    res_data     = {24'b0, lane_byte};
                    res_write_en = 1'b1;
                end
                op_ldh: begin
                    res_data     = {{16{lane_half[15]}}, lane_half};
                    res_write_en = 1'b1;
                end
                op_ldhu: begin
                    res_data     = {16'b0, lane_half};
                    res_write_en = 1'b1;
                end
                op_ldw, op_llw: begin
                    res_data     = word;
                    res_write_en = 1'b1;
                end
                op_scw: begin
                    res_data     = {{(data_width-1){1'b0}}, stage_sc_ok};  // Success flag.
                    res_write_en = 1'b1;
                end
                default: begin
                end
            endcase
        end
    end

    // Result queue.
    always_ff @(posedge clk) begin
        if (stage_valid) begin
            q_data[wr_ptr]      <= res_data;
            q_write_en[wr_ptr]  <= res_write_en;
            q_reg_addr[wr_ptr]  <= stage_reg_addr;
            q_exception[wr_ptr] <= stage_exception;
            q_exc_code[wr_ptr]  <= stage_exc_code;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else begin
            if (stage_valid) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (stage_valid && !pop) begin
                count <= count + 1'b1;
            end
            else if (!stage_valid && pop) begin
                count <= count - 1'b1;
            end
        end
    end

    assign pop           = out_pop && out_valid;
    assign credit_return = pop;  // Each pop frees one credit.

    assign out_valid        = (count != '0);
    assign out_data         = q_data[rd_ptr];
    assign out_reg_write_en = q_write_en[rd_ptr];
    assign out_reg_addr     = q_reg_addr[rd_ptr];
    assign out_exception    = q_exception[rd_ptr];
    assign out_exc_code     = q_exc_code[rd_ptr];

endmodule

`default_nettype wire

//--- design/lsu_top.sv
`default_nettype none

module lsu_top
    import lsu_pkg::*;
#(
    parameter int addr_width   = 6,
    parameter int result_depth = 4
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      in_valid,
    input  mem_op_t                   in_op,
    input  logic [addr_width+1:0]     in_addr,
    input  logic [data_width-1:0]     in_store_data,
    input  logic [reg_addr_width-1:0] in_reg_addr,
    output logic                      in_ready,
    output logic                      out_valid,
    output logic                      out_reg_write_en,
    output logic [reg_addr_width-1:0] out_reg_addr,
    output logic [data_width-1:0]     out_data,
    output logic                      out_exception,
    output exc_code_t                 out_exc_code,
    input  logic                      out_pop
);

    logic [addr_width-1:0]     word_addr;
    logic                      bank_write;
    logic [lane_count-1:0]     lane_en;
    logic [data_width-1:0]     wr_data;
    logic [lane_count-1:0][7:0] lane_data;

    logic                      stage_valid;
    mem_op_t                   stage_op;
    logic [1:0]                stage_offset;
    logic [reg_addr_width-1:0] stage_reg_addr;
    logic                      stage_exception;
    exc_code_t                 stage_exc_code;
    logic                      stage_sc_ok;
    logic                      credit_return;

    mem_access #(
        .addr_width   (addr_width),
        .result_depth (result_depth)
    ) u_mem_access (
        .clk             (clk),
        .reset           (reset),
        .in_valid        (in_valid),
        .in_op           (in_op),
        .in_addr         (in_addr),
        .in_store_data   (in_store_data),
        .in_reg_addr     (in_reg_addr),
        .credit_return   (credit_return),
        .in_ready        (in_ready),
        .word_addr       (word_addr),
        .bank_write      (bank_write),
        .lane_en         (lane_en),
        .wr_data         (wr_data),
        .stage_valid     (stage_valid),
        .stage_op        (stage_op),
        .stage_offset    (stage_offset),
        .stage_reg_addr  (stage_reg_addr),
        .stage_exception (stage_exception),
        .stage_exc_code  (stage_exc_code),
        .stage_sc_ok     (stage_sc_ok)
    );

    // One bank per byte lane.
    for (genvar i = 0; i < lane_count; i++) begin : g_lane
        data_bank #(
            .addr_width (addr_width)
        ) u_bank (
            .clk        (clk),
            .word_addr  (word_addr),
            .lane_en    (lane_en[i]),
            .bank_write (bank_write),
            .wr_byte    (wr_data[8*i +: 8]),
            .rd_byte    (lane_data[i])
        );
    end

    load_align #(
        .result_depth (result_depth)
    ) u_load_align (
        .clk              (clk),
        .reset            (reset),
        .stage_valid      (stage_valid),
        .stage_op         (stage_op),
        .stage_offset     (stage_offset),
        .stage_reg_addr   (stage_reg_addr),
        .stage_exception  (stage_exception),
        .stage_exc_code   (stage_exc_code),
        .stage_sc_ok      (stage_sc_ok),
        .lane_data        (lane_data),
        .out_pop          (out_pop),
        .out_valid        (out_valid),
        .out_reg_write_en (out_reg_write_en),
        .out_reg_addr     (out_reg_addr),
        .out_data         (out_data),
        .out_exception    (out_exception),
        .out_exc_code     (out_exc_code),
        .credit_return    (credit_return)
    );

endmodule

`default_nettype wire

//--- tests/lsu_properties.sv
`default_nettype none

// Handshake and credit checks for the load/store unit.
module lsu_properties #(
    parameter int result_depth = 4
) (
    input logic                              clk,
    input logic                              reset,
    input logic                              stage_valid,
    input logic                              out_valid,
    input logic                              out_pop,
    input logic [$clog2(result_depth+1)-1:0] credits,
    input logic [$clog2(result_depth+1)-1:0] queue_count
);

    int fail_count = 0;  // Read by the testbench at the end of the run.

    // An accept without a credit would push into a full queue.
    accept_has_room: assert property (
        @(posedge clk) disable iff (reset) stage_valid |-> queue_count < result_depth
    ) else begin
        fail_count++;
        $error("Operation accepted while the result queue had no free entry.");
    end

    pop_needs_valid: assert property (
        @(posedge clk) disable iff (reset) out_pop |-> out_valid
    ) else begin
        fail_count++;
        $error("Result popped while the queue shows no valid entry.");
    end

    credit_bound: assert property (
        @(posedge clk) disable iff (reset) credits <= result_depth
    ) else begin
        fail_count++;
        $error("Credit count above the queue depth.");
    end

endmodule

bind lsu_top lsu_properties #(
    .result_depth (result_depth)
) props (
    .clk         (clk),
    .reset       (reset),
    .stage_valid (stage_valid),
    .out_valid   (out_valid),
    .out_pop     (out_pop),
    .credits     (u_mem_access.credits),
    .queue_count (u_load_align.count)
);

`default_nettype wire

//--- tests/lsu_tb.sv
`default_nettype none

module lsu_tb
    import lsu_pkg::*;
();

    localparam int num_rows   = 41;
    localparam int wait_limit = 200;  // Cycles.

    typedef struct packed {
        mem_op_t     op;
        logic [7:0]  addr;
        logic [31:0] data;
        logic        write_en;
        logic [31:0] result;
        logic        exception;
    } op_row_t;

    logic                      clk;
    logic                      reset;
    logic                      in_valid;
    mem_op_t                   in_op;
    logic [7:0]                in_addr;
    logic [data_width-1:0]     in_store_data;
    logic [reg_addr_width-1:0] in_reg_addr;
    logic                      in_ready;
    logic                      out_valid;
    logic                      out_reg_write_en;
    logic [reg_addr_width-1:0] out_reg_addr;
    logic [data_width-1:0]     out_data;
    logic                      out_exception;
    exc_code_t                 out_exc_code;
    logic                      out_pop;
    logic                      pop_enable;

    // Columns: op, address, store data, expected write_en, expected data, expected ALE.
    op_row_t rows [num_rows] = '{
        '{op_stw,  8'h10, 32'h8899_aabb, 1'b0, 32'h0000_0000, 1'b0},
        '{op_ldw,  8'h10, 32'h0000_0000, 1'b1, 32'h8899_aabb, 1'b0},
        '{op_ldb,  8'h10, 32'h0000_0000, 1'b1, 32'hffff_ffbb, 1'b0},
        '{op_ldb,  8'h11, 32'h0000_0000, 1'b1, 32'hffff_ffaa, 1'b0},
        '{op_ldb,  8'h12, 32'h0000_0000, 1'b1, 32'hffff_ff99, 1'b0},
        '{op_ldb,  8'h13, 32'h0000_0000, 1'b1, 32'hffff_ff88, 1'b0},
        '{op_ldbu, 8'h11, 32'h0000_0000, 1'b1, 32'h0000_00aa, 1'b0},
        '{op_ldh,  8'h10, 32'h0000_0000, 1'b1, 32'hffff_aabb, 1'b0},
        '{op_ldh,  8'h12, 32'h0000_0000, 1'b1, 32'hffff_8899, 1'b0},
        '{op_ldhu, 8'h12, 32'h0000_0000, 1'b1, 32'h0000_8899, 1'b0},
        '{op_ldhu, 8'h10, 32'h0000_0000, 1'b1, 32'h0000_aabb, 1'b0},
        '{op_ldbu, 8'h12, 32'h0000_0000, 1'b1, 32'h0000_0099, 1'b0},
        '{op_sth,  8'h16, 32'h0000_1234, 1'b0, 32'h0000_0000, 1'b0},
        '{op_sth,  8'h14, 32'h0000_7f56, 1'b0, 32'h0000_0000, 1'b0},
        '{op_ldw,  8'h14, 32'h0000_0000, 1'b1, 32'h1234_7f56, 1'b0},
        '{op_ldh,  8'h14, 32'h0000_0000, 1'b1, 32'h0000_7f56, 1'b0},
        '{op_stb,  8'h15, 32'h0000_00c3, 1'b0, 32'h0000_0000, 1'b0},
        '{op_ldw,  8'h14, 32'h0000_0000, 1'b1, 32'h1234_c356, 1'b0},
        '{op_ldb,  8'h15, 32'h0000_0000, 1'b1, 32'hffff_ffc3, 1'b0},
        '{op_ldbu, 8'h14, 32'h0000_0000, 1'b1, 32'h0000_0056, 1'b0},
        '{op_ldb,  8'h17, 32'h0000_0000, 1'b1, 32'h0000_0012, 1'b0},
        '{op_ldh,  8'h11, 32'h0000_0000, 1'b0, 32'h0000_0000, 1'b1},
        '{op_sth,  8'h13, 32'hffff_ffff, 1'b0, 32'h0000_0000, 1'b1},
        '{op_stw,  8'h12, 32'hffff_ffff, 1'b0, 32'h0000_0000, 1'b1},
        '{op_ldw,  8'h11, 32'h0000_0000, 1'b0, 32'h0000_0000, 1'b1},
        '{op_llw,  8'h13, 32'h0000_0000, 1'b0, 32'h0000_0000, 1'b1},
        '{op_scw,  8'h12, 32'hffff_ffff, 1'b0, 32'h0000_0000, 1'b1},
        '{op_ldhu, 8'h17, 32'h0000_0000, 1'b0, 32'h0000_0000, 1'b1},
        '{op_ldw,  8'h10, 32'h0000_0000, 1'b1, 32'h8899_aabb, 1'b0},  // Memory unchanged.
        '{op_stw,  8'h20, 32'h0bad_f00d, 1'b0, 32'h0000_0000, 1'b0},
        '{op_llw,  8'h20, 32'h0000_0000, 1'b1, 32'h0bad_f00d, 1'b0},
        '{op_scw,  8'h20, 32'h1357_9bdf, 1'b1, 32'h0000_0001, 1'b0},
        '{op_ldw,  8'h20, 32'h0000_0000, 1'b1, 32'h1357_9bdf, 1'b0},
        '{op_scw,  8'h20, 32'h2468_ace0, 1'b1, 32'h0000_0000, 1'b0},  // Link already used.
        '{op_ldw,  8'h20, 32'h0000_0000, 1'b1, 32'h1357_9bdf, 1'b0},
        '{op_stw,  8'h30, 32'hcafe_0001, 1'b0, 32'h0000_0000, 1'b0},
        '{op_ldw,  8'h30, 32'h0000_0000, 1'b1, 32'hcafe_0001, 1'b0},
        '{op_ldbu, 8'h33, 32'h0000_0000, 1'b1, 32'h0000_00ca, 1'b0},
        '{op_ldh,  8'h32, 32'h0000_0000, 1'b1, 32'hffff_cafe, 1'b0},
        '{op_stb,  8'h30, 32'h0000_0077, 1'b0, 32'h0000_0000, 1'b0},
        '{op_ldw,  8'h30, 32'h0000_0000, 1'b1, 32'hcafe_0077, 1'b0}
    };

    lsu_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [reg_addr_width-1:0] dest_reg(input int idx);
        return reg_addr_width'(idx % 31 + 1);
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] t=%0t %s: got 0x%08h, expected 0x%08h",
                     $time, name, actual, expected);
            $display("=== FAIL ===");
            $fatal(1, "Mismatch on %s.", name);
        end
    endtask

    task automatic give_up(input string what);
        $display("Timed out waiting for %s.", what);
        $display("=== FAIL ===");
        $fatal(1, "Wait limit reached.");
    endtask

    // Called on a falling edge, returns on the falling edge after the accept.
    task automatic send_op(input int idx);
        int waited;
        waited        = 0;
        in_valid      = 1'b1;
        in_op         = rows[idx].op;
        in_addr       = rows[idx].addr;
        in_store_data = rows[idx].data;
        in_reg_addr   = dest_reg(idx);
        while (!in_ready) begin
            @(negedge clk);
            waited++;
            if (waited > wait_limit) give_up("in_ready");
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic receive_result(input int idx);
        int waited;
        bit take;
        waited = 0;
        take   = 1'b0;
        while (!take) begin
            take = out_valid && pop_enable && ($urandom_range(3) != 0);
            if (!take) begin
                @(negedge clk);
                waited++;
                if (waited > wait_limit) give_up("a result");
            end
        end
        check_value("out_reg_write_en", 32'(out_reg_write_en), 32'(rows[idx].write_en));
        check_value("out_reg_addr", 32'(out_reg_addr), 32'(dest_reg(idx)));
        check_value("out_data", out_data, rows[idx].result);
        check_value("out_exception", 32'(out_exception), 32'(rows[idx].exception));
        check_value("out_exc_code", 32'(out_exc_code),
                    32'(rows[idx].exception ? exc_ale : exc_none));
        out_pop = 1'b1;
        @(negedge clk);
        out_pop = 1'b0;
    endtask

    // Sends rows from send_first and checks results from recv_first, both up to last.
    task automatic run_rows(input int send_first, input int recv_first, input int last);
        fork
            for (int i = send_first; i <= last; i++) begin
                send_op(i);
            end
            for (int i = recv_first; i <= last; i++) begin
                receive_result(i);
            end
        join
    endtask

    initial begin
        void'($urandom(32'h2f1b_a67f));
        reset         = 1'b1;
        in_valid      = 1'b0;
        in_op         = op_ldw;
        in_addr       = '0;
        in_store_data = '0;
        in_reg_addr   = '0;
        out_pop       = 1'b0;
        pop_enable    = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_value("in_ready", 32'(in_ready), 32'd1);
        check_value("out_valid", 32'(out_valid), 32'd0);

        pop_enable = 1'b1;
        run_rows(0, 0, 34);  // Widths, misalignment and LL/SC.

        // Queue fills with no pops, so the credits run out after four accepts.
        pop_enable = 1'b0;
        for (int i = 35; i < 39; i++) begin
            send_op(i);
        end
        check_value("in_ready", 32'(in_ready), 32'd0);
        repeat (3) begin
            @(negedge clk);
            check_value("in_ready", 32'(in_ready), 32'd0);
        end
        check_value("out_valid", 32'(out_valid), 32'd1);
        pop_enable = 1'b1;
        run_rows(39, 35, num_rows - 1);

        if (DUT.props.fail_count == 0) begin
            $display("=== PASS ===");
        end
        else begin
            $display("Assertion failures: %0d", DUT.props.fail_count);
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- lsu.f
design/lsu_pkg.sv
design/data_bank.sv
design/mem_access.sv
design/load_align.sv
design/lsu_top.sv
tests/lsu_properties.sv
tests/lsu_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module lsu_tb -f lsu.f -o lsu_sim \
    || { echo "Build failed"; exit 1; }
sim_out=$(./obj_dir/lsu_sim +verilator+error+limit+100)
printf '%s\n' "$sim_out"
printf '%s\n' "$sim_out" | grep -qxF "=== PASS ===" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
